/* common/csr_pkg.sv */
`default_nettype none

package csr_pkg;

    typedef logic [31:0] xlen_t;

    // Operation carried by one CSR-type instruction
    typedef enum logic [2:0] {
        CMD_NONE  = 3'd0,
        CMD_WRITE = 3'd1,
        CMD_SET   = 3'd2,
        CMD_CLEAR = 3'd3,
        CMD_ECALL = 3'd4,
        CMD_MRET  = 3'd5
    } csr_cmd_e;

    typedef enum logic [1:0] {
        PRIV_U = 2'b00,
        PRIV_M = 2'b11
    } priv_e;

    // Machine trap setup and handling
    localparam logic [11:0] MSTATUS  = 12'h300;
    localparam logic [11:0] MISA     = 12'h301;
    localparam logic [11:0] MIE      = 12'h304;
    localparam logic [11:0] MTVEC    = 12'h305;
    localparam logic [11:0] MSCRATCH = 12'h340;
    localparam logic [11:0] MEPC     = 12'h341;
    localparam logic [11:0] MCAUSE   = 12'h342;
    localparam logic [11:0] MIP      = 12'h344;

    // User-level read-only counters
    localparam logic [11:0] CYCLE    = 12'hc00;
    localparam logic [11:0] TIME     = 12'hc01;
    localparam logic [11:0] CYCLEH   = 12'hc80;
    localparam logic [11:0] TIMEH    = 12'hc81;

    // Machine counters
    localparam logic [11:0] MCYCLE   = 12'hb00;
    localparam logic [11:0] MCYCLEH  = 12'hb80;

    // MXL = 1 (RV32), extensions A, I and M
    localparam xlen_t MISA_VALUE = 32'h4000_1101;

    // Exception codes
    localparam logic [30:0] CAUSE_ILLEGAL_INSTR = 31'd2;
    localparam logic [30:0] CAUSE_ECALL_U       = 31'd8;
    localparam logic [30:0] CAUSE_ECALL_M       = 31'd11;

    // Interrupt codes
    localparam logic [30:0] CAUSE_MSI = 31'd3;
    localparam logic [30:0] CAUSE_MTI = 31'd7;
    localparam logic [30:0] CAUSE_MEI = 31'd11;

    // Bit positions shared by mie and mip
    localparam int MSI_BIT = 3;
    localparam int MTI_BIT = 7;
    localparam int MEI_BIT = 11;

    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int MSTATUS_MPP_LSB  = 11;

    // mtvec mode field
    localparam logic [1:0] XTVEC_DIRECT   = 2'b00;
    localparam logic [1:0] XTVEC_VECTORED = 2'b01;

    typedef struct packed {
        logic mei;
        logic mti;
        logic msi;
    } irq_bits_t;

    typedef struct packed {
        logic        intr;
        logic [30:0] code;
    } cause_fields_t;

    // Same word seen as raw mcause or as flag plus code
    typedef union packed {
        xlen_t         raw;
        cause_fields_t f;
    } cause_u;

    typedef struct packed {
        csr_cmd_e    cmd;
        logic [11:0] addr;
        xlen_t       operand;
        xlen_t       pc;
    } csr_req_t;

    typedef struct packed {
        priv_e     mode;
        logic      mstatus_mie;
        logic      mstatus_mpie;
        priv_e     mstatus_mpp;
        irq_bits_t mie;
        irq_bits_t mip;
        xlen_t     mtvec;
        xlen_t     mepc;
    } csr_state_t;

    typedef struct packed {
        logic   take_trap;
        logic   do_mret;
        logic   write_en;
        cause_u cause;
    } trap_event_t;

endpackage

`default_nettype wire

/* csr_regs/csr_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_regfile (
    input  wire                      clk,
    input  wire                      rst_i,
    input  wire                      valid_i,
    input  wire csr_pkg::csr_req_t   req_i,
    input  wire csr_pkg::trap_event_t event_i,
    input  wire csr_pkg::xlen_t      rd_value_i,
    input  wire [63:0]               mtime_i,
    input  wire [63:0]               mtimecmp_i,
    input  wire                      meip_i,
    output csr_pkg::csr_state_t      state_o,
    output csr_pkg::xlen_t           mscratch_o,
    output csr_pkg::cause_u          mcause_o,
    output csr_pkg::xlen_t           rdata_o
);

    csr_pkg::priv_e     mode_q;
    logic               mstatus_mie_q;
    logic               mstatus_mpie_q;
    csr_pkg::priv_e     mstatus_mpp_q;
    csr_pkg::irq_bits_t mie_q;
    logic               mip_msi_q;
    csr_pkg::xlen_t     mtvec_q;
    csr_pkg::xlen_t     mscratch_q;
    csr_pkg::xlen_t     mepc_q;
    csr_pkg::cause_u    mcause_q;
    csr_pkg::xlen_t     rdata_q;

    csr_pkg::xlen_t     wdata;
    csr_pkg::priv_e     wdata_mpp;
    logic               timer_pending;

    // New value from the old one and the operand
    always_comb begin
        case (req_i.cmd)
            csr_pkg::CMD_WRITE: wdata = req_i.operand;
            csr_pkg::CMD_SET:   wdata = rd_value_i | req_i.operand;
            csr_pkg::CMD_CLEAR: wdata = rd_value_i & ~req_i.operand;
            default:            wdata = rd_value_i;
        endcase
    end

    // Only U and M exist, anything other than M falls back to U
    assign wdata_mpp = (wdata[csr_pkg::MSTATUS_MPP_LSB +: 2] == csr_pkg::PRIV_M) ?
                       csr_pkg::PRIV_M : csr_pkg::PRIV_U;

    assign timer_pending = (mtime_i >= mtimecmp_i);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            mode_q         <= csr_pkg::PRIV_M;
            mstatus_mie_q  <= 1'b0;
            mstatus_mpie_q <= 1'b0;
            mstatus_mpp_q  <= csr_pkg::PRIV_U;
            mie_q          <= '0;
            mip_msi_q      <= 1'b0;
            mtvec_q        <= '0;
            mscratch_q     <= '0;
            mepc_q         <= '0;
            mcause_q       <= '0;
        end else if (event_i.take_trap) begin
            mepc_q         <= req_i.pc;
            mcause_q       <= event_i.cause;
            mstatus_mpie_q <= mstatus_mie_q;
            mstatus_mie_q  <= 1'b0;
            mstatus_mpp_q  <= mode_q;
            mode_q         <= csr_pkg::PRIV_M;
        end else if (event_i.do_mret) begin
            mstatus_mie_q  <= mstatus_mpie_q;
            mstatus_mpie_q <= 1'b1;
            mode_q         <= mstatus_mpp_q;
            mstatus_mpp_q  <= csr_pkg::PRIV_U;
        end else if (event_i.write_en) begin
            case (req_i.addr)
                csr_pkg::MSTATUS: begin
                    mstatus_mie_q  <= wdata[csr_pkg::MSTATUS_MIE_BIT];
                    mstatus_mpie_q <= wdata[csr_pkg::MSTATUS_MPIE_BIT];
                    mstatus_mpp_q  <= wdata_mpp;
                end
                csr_pkg::MIE: begin
                    mie_q.mei <= wdata[csr_pkg::MEI_BIT];
                    mie_q.mti <= wdata[csr_pkg::MTI_BIT];
                    mie_q.msi <= wdata[csr_pkg::MSI_BIT];
                end
                csr_pkg::MTVEC: begin
                    // Reserved modes are stored as direct
                    mtvec_q[31:2] <= wdata[31:2];
                    mtvec_q[1:0]  <= (wdata[1:0] == csr_pkg::XTVEC_VECTORED) ?
                                     csr_pkg::XTVEC_VECTORED : csr_pkg::XTVEC_DIRECT;
                end
                csr_pkg::MSCRATCH: mscratch_q <= wdata;
                csr_pkg::MEPC:     mepc_q     <= {wdata[31:2], 2'b00};
                csr_pkg::MCAUSE:   mcause_q   <= wdata;
                // Timer and external pending bits come from outside
                csr_pkg::MIP:      mip_msi_q  <= wdata[csr_pkg::MSI_BIT];
                default: begin
                end
            endcase
        end
    end

    // Old value returned only when the instruction was not trapped
    always_ff @(posedge clk) begin
        if (rst_i) begin
            rdata_q <= '0;
        end else if (valid_i && !event_i.take_trap) begin
            rdata_q <= rd_value_i;
        end else begin
            rdata_q <= '0;
        end
    end

    always_comb begin
        state_o.mode         = mode_q;
        state_o.mstatus_mie  = mstatus_mie_q;
        state_o.mstatus_mpie = mstatus_mpie_q;
        state_o.mstatus_mpp  = mstatus_mpp_q;
        state_o.mie          = mie_q;
        state_o.mip.mei      = meip_i;
        state_o.mip.mti      = timer_pending;
        state_o.mip.msi      = mip_msi_q;
        state_o.mtvec        = mtvec_q;
        state_o.mepc         = mepc_q;
    end

    assign mscratch_o = mscratch_q;
    assign mcause_o   = mcause_q;
    assign rdata_o    = rdata_q;

endmodule

`default_nettype wire

/* csr_regs/csr_read_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_read_mux (
    input  wire [11:0]               addr_i,
    input  wire csr_pkg::csr_state_t state_i,
    input  wire csr_pkg::xlen_t      mscratch_i,
    input  wire csr_pkg::cause_u     mcause_i,
    input  wire [63:0]               cycle_i,
    input  wire [63:0]               mtime_i,
    output csr_pkg::xlen_t           rd_value_o
);

    // Interrupt bits at their mie/mip positions
    function automatic csr_pkg::xlen_t irq_word(input csr_pkg::irq_bits_t bits);
        csr_pkg::xlen_t word;
        word = '0;
        word[csr_pkg::MEI_BIT] = bits.mei;
        word[csr_pkg::MTI_BIT] = bits.mti;
        word[csr_pkg::MSI_BIT] = bits.msi;
        return word;
    endfunction

    always_comb begin
        rd_value_o = '0;
        case (addr_i)
            csr_pkg::MSTATUS: begin
                rd_value_o[csr_pkg::MSTATUS_MIE_BIT]      = state_i.mstatus_mie;
                rd_value_o[csr_pkg::MSTATUS_MPIE_BIT]     = state_i.mstatus_mpie;
                rd_value_o[csr_pkg::MSTATUS_MPP_LSB +: 2] = state_i.mstatus_mpp;
            end
            csr_pkg::MISA:     rd_value_o = csr_pkg::MISA_VALUE;
            csr_pkg::MIE:      rd_value_o = irq_word(state_i.mie);
            csr_pkg::MIP:      rd_value_o = irq_word(state_i.mip);
            csr_pkg::MTVEC:    rd_value_o = state_i.mtvec;
            csr_pkg::MSCRATCH: rd_value_o = mscratch_i;
            csr_pkg::MEPC:     rd_value_o = state_i.mepc;
            csr_pkg::MCAUSE:   rd_value_o = mcause_i.raw;
            // Counters, low and high halves
            csr_pkg::CYCLE:    rd_value_o = cycle_i[31:0];
            csr_pkg::CYCLEH:   rd_value_o = cycle_i[63:32];
            csr_pkg::MCYCLE:   rd_value_o = cycle_i[31:0];
            csr_pkg::MCYCLEH:  rd_value_o = cycle_i[63:32];
            csr_pkg::TIME:     rd_value_o = mtime_i[31:0];
            csr_pkg::TIMEH:    rd_value_o = mtime_i[63:32];
            default:           rd_value_o = '0;
        endcase
    end

endmodule

`default_nettype wire

/* src/trap_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module trap_ctrl (
    input  wire                      clk,
    input  wire                      rst_i,
    input  wire                      valid_i,
    input  wire csr_pkg::csr_req_t   req_i,
    input  wire csr_pkg::csr_state_t state_i,
    output csr_pkg::trap_event_t     event_o,
    output logic                     redirect_o,
    output csr_pkg::xlen_t           target_o
);

    logic               cmd_is_write;
    logic               priv_fault;
    logic               mret_fault;
    logic               illegal;
    logic               ecall;
    logic               raise_expt;
    logic [30:0]        expt_code;
    csr_pkg::irq_bits_t eligible;
    logic               global_ie;
    logic               raise_intr;
    logic [30:0]        intr_code;
    logic               take_trap;
    logic               do_mret;
    csr_pkg::cause_u    trap_cause;
    csr_pkg::xlen_t     vec_base;
    csr_pkg::xlen_t     trap_target;
    logic               redirect_q;
    csr_pkg::xlen_t     target_q;

    assign cmd_is_write = (req_i.cmd == csr_pkg::CMD_WRITE) ||
                          (req_i.cmd == csr_pkg::CMD_SET) ||
                          (req_i.cmd == csr_pkg::CMD_CLEAR);

    // Bits 9:8 give the lowest privilege, 11:10 == 2'b11 means read-only
    assign priv_fault = (req_i.addr[9:8] > state_i.mode) || (req_i.addr[11:10] == 2'b11);
    assign mret_fault = (req_i.cmd == csr_pkg::CMD_MRET) && (state_i.mode != csr_pkg::PRIV_M);

    assign illegal    = valid_i && ((cmd_is_write && priv_fault) || mret_fault);
    assign ecall      = valid_i && (req_i.cmd == csr_pkg::CMD_ECALL);
    assign raise_expt = illegal || ecall;

    always_comb begin
        if (illegal) begin
            expt_code = csr_pkg::CAUSE_ILLEGAL_INSTR;
        end else if (state_i.mode == csr_pkg::PRIV_M) begin
            expt_code = csr_pkg::CAUSE_ECALL_M;
        end else begin
            expt_code = csr_pkg::CAUSE_ECALL_U;
        end
    end

    // Pending and enabled, U mode is always interruptible
    assign eligible  = state_i.mip & state_i.mie;
    assign global_ie = (state_i.mode == csr_pkg::PRIV_U) || state_i.mstatus_mie;

    assign raise_intr = valid_i && global_ie && (|eligible) && !raise_expt;

    // MEI over MSI over MTI
    always_comb begin
        if (eligible.mei) begin
            intr_code = csr_pkg::CAUSE_MEI;
        end else if (eligible.msi) begin
            intr_code = csr_pkg::CAUSE_MSI;
        end else begin
            intr_code = csr_pkg::CAUSE_MTI;
        end
    end

    assign take_trap = raise_expt || raise_intr;
    assign do_mret   = valid_i && (req_i.cmd == csr_pkg::CMD_MRET) && !take_trap;

    always_comb begin
        trap_cause.f.intr = !raise_expt;
        trap_cause.f.code = raise_expt ? expt_code : intr_code;
    end

    assign event_o.take_trap = take_trap;
    assign event_o.do_mret   = do_mret;
    assign event_o.write_en  = valid_i && cmd_is_write && !take_trap;
    assign event_o.cause     = trap_cause;

    assign vec_base = {state_i.mtvec[31:2], 2'b00};

    // Exceptions always land on the base
    always_comb begin
        if (raise_intr && (state_i.mtvec[1:0] == csr_pkg::XTVEC_VECTORED)) begin
            trap_target = vec_base + {trap_cause.f.code[29:0], 2'b00};
        end else begin
            trap_target = vec_base;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            redirect_q <= 1'b0;
            target_q   <= '0;
        end else begin
            redirect_q <= take_trap || do_mret;
            if (take_trap) begin
                target_q <= trap_target;
            end else if (do_mret) begin
                target_q <= state_i.mepc;
            end else begin
                target_q <= '0;
            end
        end
    end

    assign redirect_o = redirect_q;
    assign target_o   = target_q;

endmodule

`default_nettype wire

/* src/csr_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_unit (
    input  wire                    clk,
    input  wire                    rst_i,
    input  wire                    valid_i,
    input  wire csr_pkg::csr_req_t req_i,
    input  wire [63:0]             cycle_i,
    input  wire [63:0]             mtime_i,
    input  wire [63:0]             mtimecmp_i,
    input  wire                    meip_i,
    output wire csr_pkg::xlen_t    rdata_o,
    output wire                    redirect_o,
    output wire csr_pkg::xlen_t    target_o,
    output wire csr_pkg::priv_e    mode_o
);

    wire csr_pkg::csr_state_t  state;
    wire csr_pkg::trap_event_t trap_event;
    wire csr_pkg::xlen_t       rd_value;
    wire csr_pkg::xlen_t       mscratch;
    wire csr_pkg::cause_u      mcause;

    csr_regfile u_regfile (
        .clk        (clk),
        .rst_i      (rst_i),
        .valid_i    (valid_i),
        .req_i      (req_i),
        .event_i    (trap_event),
        .rd_value_i (rd_value),
        .mtime_i    (mtime_i),
        .mtimecmp_i (mtimecmp_i),
        .meip_i     (meip_i),
        .state_o    (state),
        .mscratch_o (mscratch),
        .mcause_o   (mcause),
        .rdata_o    (rdata_o)
    );

    // Old value of the addressed CSR, same cycle
    csr_read_mux u_read_mux (
        .addr_i     (req_i.addr),
        .state_i    (state),
        .mscratch_i (mscratch),
        .mcause_i   (mcause),
        .cycle_i    (cycle_i),
        .mtime_i    (mtime_i),
        .rd_value_o (rd_value)
    );

    trap_ctrl u_trap_ctrl (
        .clk        (clk),
        .rst_i      (rst_i),
        .valid_i    (valid_i),
        .req_i      (req_i),
        .state_i    (state),
        .event_o    (trap_event),
        .redirect_o (redirect_o),
        .target_o   (target_o)
    );

    assign mode_o = state.mode;

endmodule

`default_nettype wire

/* test/tb_csr_vectors.svh */
`ifndef TB_CSR_VECTORS_SVH
`define TB_CSR_VECTORS_SVH

// Columns: cmd, addr, operand, pc, meip, mtime, mtimecmp,
// then expected redirect, target, rdata (old CSR value) and mode after the edge
task automatic load_vectors();
    // mscratch write, set and clear each return the previous value
    add_row(C_WR, 12'h340, 32'h1234_5678, 32'h0000_1000, 1'b0, 64'h0, NEVER,
            1'b0, 32'h0, 32'h0000_0000, MODE_M);
    add_row(C_SET, 12'h340, 32'h0000_00f0, 32'h0000_1004, 1'b0, 64'h0, NEVER,
            1'b0, 32'h0, 32'h1234_5678, MODE_M);
    add_row(C_CLR, 12'h340, 32'h1200_0008, 32'h0000_1008, 1'b0, 64'h0, NEVER,
            1'b0, 32'h0, 32'h1234_56f8, MODE_M);
    add_row(C_RD, 12'h340, 32'h0, 32'h0000_100c, 1'b0, 64'h0, NEVER,
            1'b0, 32'h0, 32'h0034_56f0, MODE_M);
    // Direct mtvec, then ecall from M
    add_row(C_WR, 12'h305, 32'h0000_0100, 32'h0000_1010, 1'b0, 64'h0, NEVER,
            1'b0, 32'h0, 32'h0000_0000, MODE_M);
    add_row(C_ECALL, 12'h000, 32'h0, 32'h0000_2000, 1'b0, 64'h0, NEVER,
            1'b1, 32'h0000_0100, 32'h0, MODE_M);
    add_row(C_RD, 12'h342, 32'h0, 32'h0000_0100, 1'b0, 64'h0, NEVER,
            1'b0, 32'h0, 32'h0000_000b, MODE_M);
    add_row(C_RD, 12'h341, 32'h0, 32'h0000_0104, 1'b0, 64'h0, NEVER,
            1'b0, 32'h0, 32'h0000_2000, MODE_M);
    // mpp back to U, mepc loses its low bits, then MRET
    add_row(C_WR, 12'h300, 32'h0, 32'h0000_0108, 1'b0, 64'h0, NEVER,
            1'b0, 32'h0, 32'h0000_1800, MODE_M);
    add_row(C_WR, 12'h341, 32'h0000_3003, 32'h0000_010c, 1'b0, 64'h0, NEVER,
            1'b0, 32'h0, 32'h0000_2000, MODE_M);
    add_row(C_MRET, 12'h000, 32'h0, 32'h0000_0110, 1'b0, 64'h0, NEVER,
            1'b1, 32'h0000_3000, 32'h0, MODE_U);
    // U mode write to an M register is illegal
    add_row(C_WR, 12'h340, 32'hdead_beef, 32'h0000_3000, 1'b0, 64'h0, NEVER,
            1'b1, 32'h0000_0100, 32'h0, MODE_M);
    add_row(C_RD, 12'h342, 32'h0, 32'h0000_0100, 1'b0, 64'h0, NEVER,
            1'b0, 32'h0, 32'h0000_0002, MODE_M);
    add_row(C_RD, 12'h340, 32'h0, 32'h0000_0104, 1'b0, 64'h0, NEVER,
            1'b0, 32'h0, 32'h0034_56f0, MODE_M);
    add_row(C_MRET, 12'h000, 32'h0, 32'h0000_0108, 1'b0, 64'h0, NEVER,
            1'b1, 32'h0000_3000, 32'h0, MODE_U);
    add_row(C_ECALL, 12'h000, 32'h0, 32'h0000_3004, 1'b0, 64'h0, NEVER,
            1'b1, 32'h0000_0100, 32'h0, MODE_M);
    add_row(C_RD, 12'h342, 32'h0, 32'h0000_0100, 1'b0, 64'h0, NEVER,
            1'b0, 32'h0, 32'h0000_0008, MODE_M);
    // Vectored mtvec, MTIE and MIE on, then a pending timer
    add_row(C_WR, 12'h305, 32'h0000_0101, 32'h0000_0104, 1'b0, 64'h0, NEVER,
            1'b0, 32'h0, 32'h0000_0100, MODE_M);
    add_row(C_WR, 12'h304, 32'h0000_0080, 32'h0000_0108, 1'b0, 64'h0, NEVER,
            1'b0, 32'h0, 32'h0000_0000, MODE_M);
    add_row(C_SET, 12'h300, 32'h0000_0008, 32'h0000_010c, 1'b0, 64'h0, NEVER,
            1'b0, 32'h0, 32'h0000_0000, MODE_M);
    add_row(C_WR, 12'h340, 32'h5555_aaaa, 32'h0000_4000, 1'b0, 64'h100, 64'h100,
            1'b1, 32'h0000_011c, 32'h0, MODE_M);
    add_row(C_RD, 12'h342, 32'h0, 32'h0000_0104, 1'b0, 64'h0, NEVER,
            1'b0, 32'h0, 32'h8000_0007, MODE_M);
    add_row(C_RD, 12'h340, 32'h0, 32'h0000_0108, 1'b0, 64'h0, NEVER,
            1'b0, 32'h0, 32'h0034_56f0, MODE_M);
    // MEIE too, the illegal write beats both pending interrupts
    add_row(C_WR, 12'h304, 32'h0000_0880, 32'h0000_010c, 1'b0, 64'h0, NEVER,
            1'b0, 32'h0, 32'h0000_0080, MODE_M);
    add_row(C_SET, 12'h300, 32'h0000_0008, 32'h0000_0110, 1'b0, 64'h0, NEVER,
            1'b0, 32'h0, 32'h0000_1880, MODE_M);
    add_row(C_WR, 12'hc00, 32'h0000_0001, 32'h0000_5000, 1'b1, 64'h200, 64'h100,
            1'b1, 32'h0000_0100, 32'h0, MODE_M);
    add_row(C_RD, 12'h342, 32'h0, 32'h0000_0100, 1'b0, 64'h0, NEVER,
            1'b0, 32'h0, 32'h0000_0002, MODE_M);
    add_row(C_SET, 12'h300, 32'h0000_0008, 32'h0000_0104, 1'b0, 64'h0, NEVER,
            1'b0, 32'h0, 32'h0000_1880, MODE_M);
    // External wins over timer
    add_row(C_RD, 12'h340, 32'h0, 32'h0000_6000, 1'b1, 64'h200, 64'h100,
            1'b1, 32'h0000_012c, 32'h0, MODE_M);
    add_row(C_RD, 12'h342, 32'h0, 32'h0000_0100, 1'b0, 64'h0, NEVER,
            1'b0, 32'h0, 32'h8000_000b, MODE_M);
    add_row(C_RD, 12'h344, 32'h0, 32'h0000_0104, 1'b1, 64'h200, 64'h100,
            1'b0, 32'h0, 32'h0000_0880, MODE_M);
    // Counters are read-only
    add_row(C_WR, 12'hc00, 32'h0000_0001, 32'h0000_7000, 1'b0, 64'h0, NEVER,
            1'b1, 32'h0000_0100, 32'h0, MODE_M);
    add_row(C_RD, 12'h342, 32'h0, 32'h0000_0100, 1'b0, 64'h0, NEVER,
            1'b0, 32'h0, 32'h0000_0002, MODE_M);
    // Counter advances by one per row, this is row 33
    add_row(C_RD, 12'hc00, 32'h0, 32'h0000_0104, 1'b0, 64'h0, NEVER,
            1'b0, 32'h0, 32'h0000_0121, MODE_M);
    add_row(C_RD, 12'hc80, 32'h0, 32'h0000_0108, 1'b0, 64'h0, NEVER,
            1'b0, 32'h0, 32'h0000_0002, MODE_M);
    // RV32 with A, I and M
    add_row(C_RD, 12'h301, 32'h0, 32'h0000_010c, 1'b0, 64'h0, NEVER,
            1'b0, 32'h0, 32'h4000_1101, MODE_M);
    add_row(C_RD, 12'hc01, 32'h0, 32'h0000_0110, 1'b0, 64'h0000_0007_0000_0042, NEVER,
            1'b0, 32'h0, 32'h0000_0042, MODE_M);
endtask

`endif

/* test/tb_csr_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_csr_unit;

    // Counter value at row 0; high half stays 2 for the whole run
    localparam logic [63:0] CYCLE_START = 64'h0000_0002_0000_0100;
    localparam logic [63:0] NEVER       = 64'hffff_ffff_ffff_ffff;
    localparam int          SETTLE_MAX  = 10;

    localparam csr_pkg::csr_cmd_e C_RD    = csr_pkg::CMD_NONE;
    localparam csr_pkg::csr_cmd_e C_WR    = csr_pkg::CMD_WRITE;
    localparam csr_pkg::csr_cmd_e C_SET   = csr_pkg::CMD_SET;
    localparam csr_pkg::csr_cmd_e C_CLR   = csr_pkg::CMD_CLEAR;
    localparam csr_pkg::csr_cmd_e C_ECALL = csr_pkg::CMD_ECALL;
    localparam csr_pkg::csr_cmd_e C_MRET  = csr_pkg::CMD_MRET;
    localparam csr_pkg::priv_e    MODE_M  = csr_pkg::PRIV_M;
    localparam csr_pkg::priv_e    MODE_U  = csr_pkg::PRIV_U;

    typedef struct packed {
        csr_pkg::csr_cmd_e cmd;
        logic [11:0]       addr;
        csr_pkg::xlen_t    operand;
        csr_pkg::xlen_t    pc;
        logic              meip;
        logic [63:0]       mtime;
        logic [63:0]       mtimecmp;
        logic              exp_redirect;
        csr_pkg::xlen_t    exp_target;
        csr_pkg::xlen_t    exp_rdata;
        csr_pkg::priv_e    exp_mode;
    } vector_t;

    logic               clk;
    logic               rst_i;
    logic               valid_i;
    csr_pkg::csr_req_t  req;
    logic [63:0]        cycle_i;
    logic [63:0]        mtime_i;
    logic [63:0]        mtimecmp_i;
    logic               meip_i;
    csr_pkg::xlen_t     rdata_o;
    logic               redirect_o;
    csr_pkg::xlen_t     target_o;
    csr_pkg::priv_e     mode_o;

    vector_t vectors[$];
    int      error_count;
    int      check_count;
    int      row_errors;

    csr_unit dut (
        .clk        (clk),
        .rst_i      (rst_i),
        .valid_i    (valid_i),
        .req_i      (req),
        .cycle_i    (cycle_i),
        .mtime_i    (mtime_i),
        .mtimecmp_i (mtimecmp_i),
        .meip_i     (meip_i),
        .rdata_o    (rdata_o),
        .redirect_o (redirect_o),
        .target_o   (target_o),
        .mode_o     (mode_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic add_row(input csr_pkg::csr_cmd_e cmd, input logic [11:0] addr,
                           input csr_pkg::xlen_t operand, input csr_pkg::xlen_t pc,
                           input logic meip, input logic [63:0] mtime,
                           input logic [63:0] mtimecmp, input logic exp_redirect,
                           input csr_pkg::xlen_t exp_target, input csr_pkg::xlen_t exp_rdata,
                           input csr_pkg::priv_e exp_mode);
        vector_t v;
        v = '{cmd, addr, operand, pc, meip, mtime, mtimecmp,
              exp_redirect, exp_target, exp_rdata, exp_mode};
        vectors.push_back(v);
    endtask

    `include "tb_csr_vectors.svh"

    task automatic next_falling_edge();
        @(negedge clk);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("ERR at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        error_count = error_count + 1;
        row_errors  = row_errors + 1;
    endtask

    task automatic apply_row(input int index);
        vector_t v;
        v = vectors[index];
        valid_i     = 1'b1;
        req.cmd     = v.cmd;
        req.addr    = v.addr;
        req.operand = v.operand;
        req.pc      = v.pc;
        meip_i      = v.meip;
        mtime_i     = v.mtime;
        mtimecmp_i  = v.mtimecmp;
        cycle_i     = CYCLE_START + 64'(index);
    endtask

    task automatic check_row(input int index);
        vector_t v;
        v = vectors[index];
        row_errors  = 0;
        check_count = check_count + 4;
        if (redirect_o !== v.exp_redirect) begin
            report_mismatch("redirect_o", 32'(v.exp_redirect), 32'(redirect_o));
        end
        if (target_o !== v.exp_target) begin
            report_mismatch("target_o", v.exp_target, target_o);
        end
        if (rdata_o !== v.exp_rdata) begin
            report_mismatch("rdata_o", v.exp_rdata, rdata_o);
        end
        if (mode_o !== v.exp_mode) begin
            report_mismatch("mode_o", 32'(v.exp_mode), 32'(mode_o));
        end
        $display("row %0d %s addr %h: %s", index, v.cmd.name(), v.addr,
                 (row_errors == 0) ? "ok" : "mismatch");
    endtask

    initial begin
        int settle;
        error_count = 0;
        check_count = 0;
        row_errors  = 0;
        rst_i       = 1'b1;
        valid_i     = 1'b0;
        req         = '0;
        cycle_i     = CYCLE_START;
        mtime_i     = 64'h0;
        mtimecmp_i  = NEVER;
        meip_i      = 1'b0;
        load_vectors();

        repeat (5) next_falling_edge();
        rst_i  = 1'b0;
        settle = 0;
        while (!((redirect_o === 1'b0) && (rdata_o === 32'h0) && (mode_o === MODE_M)) &&
               (settle < SETTLE_MAX)) begin
            next_falling_edge();
            settle = settle + 1;
        end

        if (settle >= SETTLE_MAX) begin
            $display("Timeout: DUT outputs did not reach reset values after reset release");
            $display("ERRORS FOUND");
        end else begin
            next_falling_edge();
            for (int i = 0; i < vectors.size(); i++) begin
                apply_row(i);
                next_falling_edge();
                check_row(i);
            end
            valid_i = 1'b0;
            $display("%0d rows, %0d checks, %0d errors", vectors.size(), check_count,
                     error_count);
            if (error_count == 0) begin
                $display("NO ERRORS");
            end else begin
                $display("ERRORS FOUND");
            end
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+test
common/csr_pkg.sv
csr_regs/csr_regfile.sv
csr_regs/csr_read_mux.sv
src/trap_ctrl.sv
src/csr_unit.sv
test/tb_csr_unit.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_csr_unit
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
PASS_MSG  ?= NO ERRORS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
